// File: Bender.yml
package:
  name: cp0

sources:
  - files:
      - logic/cp0_pkg.sv
      - logic/cp0_exc_arbiter.sv
      - logic/cp0_regs.sv
      - logic/cp0_top.sv
  - target: test
    files:
      - testbench/cp0_assertions.sv
      - testbench/cp0_tb.sv

// File: logic/cp0_exc_arbiter.sv
`timescale 1ns/1ps

module cp0_exc_arbiter import cp0_pkg::*; #(
	parameter logic [31:0] EXC_VECTOR = 32'hbfc0_0380
) (
	input  commit_slot_t slot1_i,
	input  commit_slot_t slot2_i,
	input  logic  [31:0] status_i,
	input  logic  [31:0] cause_i,
	input  logic  [31:0] epc_i,
	input  logic         stall_i,
	output exc_event_t   event_o,
	output logic         flush_o,
	output logic  [31:0] redirect_pc_o
);

	logic [7:0] int_masked;
	logic       int_pending;
	logic       slot1_exc;
	logic       slot2_exc;

	// build the event for one slot with the given code
	function automatic exc_event_t make_event(input commit_slot_t s, input exc_code_e code);
		exc_event_t ev;
		ev = '0;
		ev.code = code;
		if (code == EXC_ERET) begin
			ev.eret = 1'b1; // only clears exl, no field updates
		end else begin
			ev.take = 1'b1;
			ev.bd = s.in_delay_slot;
			if (s.in_delay_slot) begin
				ev.epc = s.pc - 32'd4; // point back at the branch
			end else begin
				ev.epc = s.pc;
			end
			ev.bad_addr = s.bad_addr;
			ev.bad_valid = (code == EXC_ADEL) || (code == EXC_ADES);
		end
		return ev;
	endfunction

	assign int_masked = cause_i[CAUSE_IP_HI:CAUSE_IP_LO] & status_i[STATUS_IM_HI:STATUS_IM_LO];
	assign int_pending = status_i[STATUS_IE] & ~status_i[STATUS_EXL] & (|int_masked);

	assign slot1_exc = slot1_i.valid && (slot1_i.exc != EXC_NONE);
	assign slot2_exc = slot2_i.valid && (slot2_i.exc != EXC_NONE);

	// slot 1 is older, interrupt rides on it
	always_comb begin
		event_o = '0;
		event_o.code = EXC_NONE;
		if (slot1_i.valid && int_pending) begin
			event_o = make_event(slot1_i, EXC_INT);
		end else if (slot1_exc) begin
			event_o = make_event(slot1_i, slot1_i.exc);
		end else if (slot2_exc) begin
			event_o = make_event(slot2_i, slot2_i.exc);
		end
	end

	assign flush_o = (event_o.take | event_o.eret) & ~stall_i;

	// eret returns to the epc held now
	assign redirect_pc_o = event_o.eret ? epc_i : EXC_VECTOR;

endmodule

// File: logic/cp0_pkg.sv
package cp0_pkg;

	// cp0 register numbers (rd field of mtc0/mfc0)
	typedef enum logic [4:0] {
		ADDR_BADVADDR = 5'd8,
		ADDR_COUNT    = 5'd9,
		ADDR_COMPARE  = 5'd11,
		ADDR_STATUS   = 5'd12,
		ADDR_CAUSE    = 5'd13,
		ADDR_EPC      = 5'd14,
		ADDR_PRID     = 5'd15,
		ADDR_CONFIG   = 5'd16
	} cp0_addr_e;

	// values match Cause.ExcCode, except the two pseudo codes at the top
	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_SYS  = 5'd8,
		EXC_BP   = 5'd9,
		EXC_RI   = 5'd10,
		EXC_OV   = 5'd12,
		EXC_TR   = 5'd13,
		EXC_NONE = 5'd30,
		EXC_ERET = 5'd31
	} exc_code_e;

	// status fields
	localparam int STATUS_IE    = 0;
	localparam int STATUS_EXL   = 1;
	localparam int STATUS_IM_HI = 15;
	localparam int STATUS_IM_LO = 8;

	// cause fields
	localparam int CAUSE_BD      = 31;
	localparam int CAUSE_IP_HI   = 15;
	localparam int CAUSE_IP_LO   = 8;
	localparam int CAUSE_HWIP_LO = 10; // ip[7:2] are hardware lines
	localparam int CAUSE_EXC_HI  = 6;
	localparam int CAUSE_EXC_LO  = 2;

	// software writable cause bits: ip[1:0], wp, iv
	localparam logic [31:0] CAUSE_WR_MASK = 32'h00c0_0300;

	localparam logic [31:0] STATUS_RESET = 32'h0040_0000; // bev only
	localparam logic [31:0] PRID_RESET   = 32'h004c_0102;
	localparam logic [31:0] CONFIG_RESET = 32'h0000_8000;

	// one instruction leaving the commit stage
	typedef struct packed {
		logic         valid;
		exc_code_e    exc;
		logic  [31:0] pc;
		logic         in_delay_slot;
		logic  [31:0] bad_addr;
	} commit_slot_t;

	// one mtc0 write port
	typedef struct packed {
		logic         we;
		cp0_addr_e    addr;
		logic  [31:0] data;
	} cp0_wr_t;

	// arbiter decision, applied by the register block
	typedef struct packed {
		logic         take;
		logic         eret;
		exc_code_e    code;
		logic  [31:0] epc;
		logic         bd;
		logic  [31:0] bad_addr;
		logic         bad_valid;
	} exc_event_t;

endpackage

// File: logic/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs import cp0_pkg::*; #(
	parameter logic [31:0] PRID_VALUE = PRID_RESET
) (
	input  logic         clk,
	input  logic         reset_i,
	input  logic         stall_i,
	input  cp0_wr_t      wr1_i,
	input  cp0_wr_t      wr2_i,
	input  cp0_addr_e    raddr1_i,
	input  cp0_addr_e    raddr2_i,
	input  logic   [5:0] int_i,
	input  exc_event_t   event_i,
	output logic  [31:0] rdata1_o,
	output logic  [31:0] rdata2_o,
	output logic  [31:0] status_o,
	output logic  [31:0] cause_o,
	output logic  [31:0] epc_o,
	output logic  [31:0] count_o,
	output logic         timer_int_o
);

	logic [32:0] count; // bit 0 halves the rate
	logic [31:0] compare;
	logic [31:0] badvaddr;
	cp0_wr_t     wr;
	logic        timer_hit;

	// only one write per cycle takes effect, port 2 has priority
	assign wr = wr2_i.we ? wr2_i : wr1_i;

	assign count_o = count[32:1];
	assign timer_hit = (compare != 32'd0) && (count_o == compare);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			count       <= '0;
			compare     <= '0;
			status_o    <= STATUS_RESET;
			cause_o     <= '0;
			epc_o       <= '0;
			badvaddr    <= '0;
			timer_int_o <= 1'b0;
		end else if (!stall_i) begin
			count <= count + 33'd1;
			if (timer_hit) begin
				timer_int_o <= 1'b1;
			end

			// software write
			if (wr.we) begin
				case (wr.addr)
					ADDR_COUNT: begin
						count[32:1] <= wr.data;
					end
					ADDR_COMPARE: begin
						compare     <= wr.data;
						timer_int_o <= 1'b0; // ack timer irq
					end
					ADDR_STATUS: begin
						status_o <= wr.data;
					end
					ADDR_CAUSE: begin
						cause_o <= (cause_o & ~CAUSE_WR_MASK) | (wr.data & CAUSE_WR_MASK);
					end
					ADDR_EPC: begin
						epc_o <= wr.data;
					end
					default: begin
					end
				endcase
			end

			// hw lines, timer shares ip7
			cause_o[CAUSE_IP_HI:CAUSE_HWIP_LO] <= int_i | {timer_int_o, 5'b0};

			// exception fields win over the write above
			if (event_i.take) begin
				status_o[STATUS_EXL] <= 1'b1;
				cause_o[CAUSE_BD] <= event_i.bd;
				cause_o[CAUSE_EXC_HI:CAUSE_EXC_LO] <= event_i.code;
				epc_o <= event_i.epc;
				if (event_i.bad_valid) begin
					badvaddr <= event_i.bad_addr;
				end
			end else if (event_i.eret) begin
				status_o[STATUS_EXL] <= 1'b0;
			end
		end
	end

	function automatic logic [31:0] read_reg(input cp0_addr_e addr);
		logic [31:0] data;
		case (addr)
			ADDR_COUNT: begin
				data = count_o;
			end
			ADDR_COMPARE: begin
				data = compare;
			end
			ADDR_STATUS: begin
				data = status_o;
			end
			ADDR_CAUSE: begin
				data = cause_o;
			end
			ADDR_EPC: begin
				data = epc_o;
			end
			ADDR_PRID: begin
				data = PRID_VALUE;
			end
			ADDR_CONFIG: begin
				data = CONFIG_RESET; // read only
			end
			ADDR_BADVADDR: begin
				data = badvaddr;
			end
			default: begin
				data = 32'd0;
			end
		endcase
		return data;
	endfunction

	// mfc0 ports, same cycle
	always_comb begin
		if (reset_i) begin
			rdata1_o = 32'd0;
			rdata2_o = 32'd0;
		end else begin
			rdata1_o = read_reg(raddr1_i);
			rdata2_o = read_reg(raddr2_i);
		end
	end

endmodule

// File: logic/cp0_top.sv
`timescale 1ns/1ps

module cp0_top import cp0_pkg::*; #(
	parameter logic [31:0] EXC_VECTOR = 32'hbfc0_0380,
	parameter logic [31:0] PRID_VALUE = PRID_RESET
) (
	input  logic         clk,
	input  logic         reset_i,
	input  commit_slot_t slot1_i, // older
	input  commit_slot_t slot2_i,
	input  cp0_wr_t      wr1_i,
	input  cp0_wr_t      wr2_i,
	input  cp0_addr_e    raddr1_i,
	input  cp0_addr_e    raddr2_i,
	output logic  [31:0] rdata1_o,
	output logic  [31:0] rdata2_o,
	input  logic   [5:0] int_i,
	input  logic         stall_i,
	output logic         flush_o,
	output logic  [31:0] redirect_pc_o,
	output logic  [31:0] status_o,
	output logic  [31:0] cause_o,
	output logic  [31:0] epc_o,
	output logic  [31:0] count_o,
	output logic         timer_int_o
);

	exc_event_t exc_event;

	cp0_exc_arbiter #(
		.EXC_VECTOR(EXC_VECTOR)
	) i_arbiter (
		.slot1_i      (slot1_i),
		.slot2_i      (slot2_i),
		.status_i     (status_o),
		.cause_i      (cause_o),
		.epc_i        (epc_o),
		.stall_i      (stall_i),
		.event_o      (exc_event),
		.flush_o      (flush_o),
		.redirect_pc_o(redirect_pc_o)
	);

	cp0_regs #(
		.PRID_VALUE(PRID_VALUE)
	) i_regs (
		.clk        (clk),
		.reset_i    (reset_i),
		.stall_i    (stall_i),
		.wr1_i      (wr1_i),
		.wr2_i      (wr2_i),
		.raddr1_i   (raddr1_i),
		.raddr2_i   (raddr2_i),
		.int_i      (int_i),
		.event_i    (exc_event),
		.rdata1_o   (rdata1_o),
		.rdata2_o   (rdata2_o),
		.status_o   (status_o),
		.cause_o    (cause_o),
		.epc_o      (epc_o),
		.count_o    (count_o),
		.timer_int_o(timer_int_o)
	);

endmodule

// File: sources.f
logic/cp0_pkg.sv
logic/cp0_exc_arbiter.sv
logic/cp0_regs.sv
logic/cp0_top.sv
testbench/cp0_assertions.sv
testbench/cp0_tb.sv

// File: testbench/cp0_assertions.sv
`timescale 1ns/1ps

module cp0_assertions import cp0_pkg::*; (
	input logic         clk,
	input logic         reset_i,
	input logic         stall_i,
	input cp0_wr_t      wr1_i,
	input cp0_wr_t      wr2_i,
	input exc_event_t   event_i,
	input logic  [31:0] status_i,
	input logic  [31:0] cause_i,
	input logic  [31:0] epc_i,
	input logic  [32:0] count_i,
	input logic  [31:0] compare_i,
	input logic  [31:0] badvaddr_i,
	input logic         timer_int_i
);

	logic compare_wr;
	logic status_wr;
	int unsigned fail_count = 0; // failed assertions so far

	// the write that actually lands, port 2 first
	assign compare_wr = wr2_i.we ? (wr2_i.addr == ADDR_COMPARE)
		: (wr1_i.we && (wr1_i.addr == ADDR_COMPARE));
	assign status_wr = wr2_i.we ? (wr2_i.addr == ADDR_STATUS)
		: (wr1_i.we && (wr1_i.addr == ADDR_STATUS));

	stall_holds: assert property (@(posedge clk) disable iff (reset_i)
		stall_i |=> $stable(status_i) && $stable(cause_i) && $stable(epc_i)
			&& $stable(count_i) && $stable(compare_i) && $stable(badvaddr_i)
			&& $stable(timer_int_i))
		else begin
			$error("a CP0 register changed while the pipeline was stalled");
			fail_count++;
		end

	// entry sets exl and loads epc while eret drops exl
	event_applied: assert property (@(posedge clk) disable iff (reset_i)
		!stall_i && (event_i.take || event_i.eret) |=>
			(status_i[STATUS_EXL] == $past(event_i.take))
			&& (!$past(event_i.take) || (epc_i == $past(event_i.epc))))
		else begin
			$error("Status.EXL or EPC did not follow the exception event");
			fail_count++;
		end

	// exl only comes up through an exception or an mtc0 to status
	exl_needs_take: assert property (@(posedge clk) disable iff (reset_i)
		!stall_i && !status_i[STATUS_EXL] && !event_i.take && !status_wr
			|=> !status_i[STATUS_EXL])
		else begin
			$error("Status.EXL was set without an exception being taken");
			fail_count++;
		end

	timer_held: assert property (@(posedge clk) disable iff (reset_i)
		timer_int_i && !(compare_wr && !stall_i) |=> timer_int_i)
		else begin
			$error("timer interrupt dropped without a Compare write");
			fail_count++;
		end

endmodule

bind cp0_regs cp0_assertions i_assertions (
	.clk        (clk),
	.reset_i    (reset_i),
	.stall_i    (stall_i),
	.wr1_i      (wr1_i),
	.wr2_i      (wr2_i),
	.event_i    (event_i),
	.status_i   (status_o),
	.cause_i    (cause_o),
	.epc_i      (epc_o),
	.count_i    (count),
	.compare_i  (compare),
	.badvaddr_i (badvaddr),
	.timer_int_i(timer_int_o)
);

// File: testbench/cp0_tb.sv
`timescale 1ns/1ps

module cp0_tb import cp0_pkg::*; ();

	localparam logic [31:0] EXC_VECTOR = 32'h8000_0180;
	localparam logic [31:0] PRID_VALUE = 32'h0001_9300;
	localparam logic [31:0] BEV_ONLY = 32'h0040_0000;
	localparam int RESET_CYCLES = 8;
	localparam int PLAN_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = 2 * PLAN_CYCLES;

	typedef struct packed {
		logic [32:0] count;
		logic [31:0] compare;
		logic [31:0] status;
		logic [31:0] cause;
		logic [31:0] epc;
		logic [31:0] badvaddr;
		logic        timer;
	} model_t;

	typedef struct packed {
		commit_slot_t slot1;
		commit_slot_t slot2;
		cp0_wr_t      wr1;
		cp0_wr_t      wr2;
		cp0_addr_e    raddr1;
		cp0_addr_e    raddr2;
		logic   [5:0] irq;
		logic         stall;
	} stim_t;

	logic        clk;
	logic        reset_i;
	stim_t       stim;
	model_t      model;
	int unsigned cycles;
	logic [31:0] rdata1;
	logic [31:0] rdata2;
	logic [31:0] redirect_pc;
	logic [31:0] status;
	logic [31:0] cause;
	logic [31:0] epc;
	logic [31:0] count;
	logic        flush;
	logic        timer_int;

	cp0_addr_e addr_list [9] = '{ADDR_BADVADDR, ADDR_COUNT, ADDR_COMPARE, ADDR_STATUS,
		ADDR_CAUSE, ADDR_EPC, ADDR_PRID, ADDR_CONFIG, cp0_addr_e'(5'd3)};
	exc_code_e code_list [10] = '{EXC_ADEL, EXC_ADES, EXC_SYS, EXC_BP, EXC_RI, EXC_OV,
		EXC_TR, EXC_ERET, EXC_NONE, EXC_NONE};

	cp0_top #(
		.EXC_VECTOR(EXC_VECTOR),
		.PRID_VALUE(PRID_VALUE)
	) i_dut (
		.clk          (clk),
		.reset_i      (reset_i),
		.slot1_i      (stim.slot1),
		.slot2_i      (stim.slot2),
		.wr1_i        (stim.wr1),
		.wr2_i        (stim.wr2),
		.raddr1_i     (stim.raddr1),
		.raddr2_i     (stim.raddr2),
		.rdata1_o     (rdata1),
		.rdata2_o     (rdata2),
		.int_i        (stim.irq),
		.stall_i      (stim.stall),
		.flush_o      (flush),
		.redirect_pc_o(redirect_pc),
		.status_o     (status),
		.cause_o      (cause),
		.epc_o        (epc),
		.count_o      (count),
		.timer_int_o  (timer_int)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic model_t reset_model();
		model_t m;
		m = '0;
		m.status = BEV_ONLY;
		return m;
	endfunction

	function automatic logic irq_pending(input model_t m);
		logic [7:0] active;
		active = m.cause[15:8] & m.status[15:8];
		return m.status[0] && !m.status[1] && (active != 8'd0);
	endfunction

	// 0 nothing, 1 or 2 the slot that takes the event
	function automatic int pick_slot(input model_t m, input stim_t s);
		if (s.slot1.valid && (irq_pending(m) || s.slot1.exc != EXC_NONE)) begin
			return 1;
		end
		if (s.slot2.valid && s.slot2.exc != EXC_NONE) begin
			return 2;
		end
		return 0;
	endfunction

	function automatic exc_code_e pick_code(input model_t m, input stim_t s);
		case (pick_slot(m, s))
			1: return irq_pending(m) ? EXC_INT : s.slot1.exc;
			2: return s.slot2.exc;
			default: return EXC_NONE;
		endcase
	endfunction

	function automatic logic [31:0] read_model(input model_t m, input cp0_addr_e addr);
		case (addr)
			ADDR_COUNT: return m.count[32:1];
			ADDR_COMPARE: return m.compare;
			ADDR_STATUS: return m.status;
			ADDR_CAUSE: return m.cause;
			ADDR_EPC: return m.epc;
			ADDR_PRID: return PRID_VALUE;
			ADDR_CONFIG: return CONFIG_RESET;
			ADDR_BADVADDR: return m.badvaddr;
			default: return 32'd0;
		endcase
	endfunction

	// next register state after one clock with these inputs
	function automatic model_t next_state(input model_t m, input stim_t s);
		model_t       n;
		cp0_wr_t      w;
		commit_slot_t src;
		exc_code_e    code;
		n = m;
		if (s.stall) begin
			return n;
		end
		n.count = m.count + 33'd1;
		if (m.compare != 32'd0 && m.count[32:1] == m.compare) begin
			n.timer = 1'b1;
		end
		w = s.wr2.we ? s.wr2 : s.wr1;
		if (w.we) begin
			case (w.addr)
				ADDR_COUNT: n.count[32:1] = w.data;
				ADDR_COMPARE: begin
					n.compare = w.data;
					n.timer = 1'b0;
				end
				ADDR_STATUS: n.status = w.data;
				ADDR_CAUSE: n.cause = (m.cause & ~CAUSE_WR_MASK) | (w.data & CAUSE_WR_MASK);
				ADDR_EPC: n.epc = w.data;
				default: ;
			endcase
		end
		n.cause[15:10] = s.irq | {m.timer, 5'b0}; // timer on ip7
		code = pick_code(m, s);
		src = (pick_slot(m, s) == 2) ? s.slot2 : s.slot1;
		if (code == EXC_ERET) begin
			n.status[1] = 1'b0;
		end else if (code != EXC_NONE) begin
			n.status[1] = 1'b1;
			n.cause[31] = src.in_delay_slot;
			n.cause[6:2] = code;
			n.epc = src.in_delay_slot ? src.pc - 32'd4 : src.pc;
			if (code == EXC_ADEL || code == EXC_ADES) begin
				n.badvaddr = src.bad_addr;
			end
		end
		return n;
	endfunction

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// the bound checker counts its own failures
	task automatic stop_on_assertion_failure();
		assert (i_dut.i_regs.i_assertions.fail_count == 0) else begin
			$display("a concurrent assertion on the CP0 register block failed");
			$display("** FAIL **");
			$fatal(1, "assertion failure");
		end
	endtask

	// comb outputs at the edge, registers just after it
	initial begin
		exc_code_e code;
		model = reset_model();
		forever begin
			@(posedge clk);
			if (reset_i) begin
				check_word("rdata1_o", rdata1, 32'd0);
				check_word("rdata2_o", rdata2, 32'd0);
				model = reset_model();
			end else begin
				check_word("rdata1_o", rdata1, read_model(model, stim.raddr1));
				check_word("rdata2_o", rdata2, read_model(model, stim.raddr2));
				code = pick_code(model, stim);
				check_word("flush_o", {31'd0, flush},
					{31'd0, (code != EXC_NONE) && !stim.stall});
				if (code != EXC_NONE) begin
					check_word("redirect_pc_o", redirect_pc,
						(code == EXC_ERET) ? model.epc : EXC_VECTOR);
				end
				model = next_state(model, stim);
			end
			#1;
			check_word("status_o", status, model.status);
			check_word("cause_o", cause, model.cause);
			check_word("epc_o", epc, model.epc);
			check_word("count_o", count, model.count[32:1]);
			check_word("timer_int_o", {31'd0, timer_int}, {31'd0, model.timer});
		end
	end

	always @(negedge clk) begin
		stop_on_assertion_failure();
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
	end

	initial begin
		cycles = 0;
		wait (cycles > TIMEOUT_CYCLES);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$fatal(1, "timeout");
	end

	function automatic stim_t idle_stim();
		stim_t s;
		s = '0;
		s.slot1.exc = EXC_NONE;
		s.slot2.exc = EXC_NONE;
		s.raddr1 = ADDR_STATUS;
		s.raddr2 = ADDR_CAUSE;
		return s;
	endfunction

	function automatic stim_t write_stim(input cp0_addr_e addr, input logic [31:0] data);
		stim_t s;
		s = idle_stim();
		s.wr1.we = 1'b1;
		s.wr1.addr = addr;
		s.wr1.data = data;
		return s;
	endfunction

	function automatic cp0_addr_e rand_addr();
		if ($urandom_range(3) == 0) begin
			return cp0_addr_e'($urandom_range(31)); // mostly unmapped
		end
		return addr_list[$urandom_range(7)];
	endfunction

	function automatic cp0_wr_t rand_write();
		cp0_wr_t w;
		w.we = $urandom_range(1);
		w.addr = rand_addr();
		w.data = $urandom;
		return w;
	endfunction

	function automatic commit_slot_t rand_slot();
		commit_slot_t c;
		c.valid = ($urandom_range(3) != 0);
		c.exc = code_list[$urandom_range(9)];
		c.pc = $urandom & 32'hffff_fffc;
		c.in_delay_slot = $urandom_range(1);
		c.bad_addr = $urandom;
		return c;
	endfunction

	task automatic drive_cycle(input stim_t s);
		stim = s;
		@(negedge clk);
	endtask

	task automatic random_cycles(input int n, input bit writes, input bit slots,
			input bit irqs, input int stall_pct);
		stim_t s;
		int    i;
		for (i = 0; i < n; i++) begin
			s = idle_stim();
			s.raddr1 = addr_list[i % 9]; // sweep every register
			s.raddr2 = rand_addr();
			if (writes) begin
				s.wr1 = rand_write();
				s.wr2 = rand_write();
			end
			if (slots) begin
				s.slot1 = rand_slot();
				s.slot2 = rand_slot();
			end
			if (irqs) begin
				s.irq = $urandom;
			end
			s.stall = ($urandom_range(99) < stall_pct);
			drive_cycle(s);
		end
	endtask

	task automatic wait_timer_rise();
		int n;
		n = 0;
		while (!timer_int && n < 100) begin
			drive_cycle(idle_stim());
			n++;
		end
		assert (timer_int) else begin
			$display("timer interrupt never rose after the Count/Compare match");
			$display("** FAIL **");
			$fatal(1, "no timer interrupt");
		end
	endtask

	initial begin
		stim_t s;
		void'($urandom(32'hc20bce61));
		stim = idle_stim();
		reset_i = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset_i = 1'b0;

		random_cycles(18, 1'b0, 1'b0, 1'b0, 0); // reset values
		random_cycles(600, 1'b1, 1'b0, 1'b1, 0);

		drive_cycle(write_stim(ADDR_STATUS, 32'd0));
		drive_cycle(write_stim(ADDR_COMPARE, 32'd0));
		random_cycles(500, 1'b0, 1'b1, 1'b0, 0); // exceptions and eret

		drive_cycle(write_stim(ADDR_COUNT, 32'd0));
		drive_cycle(write_stim(ADDR_COMPARE, 32'd30));
		wait_timer_rise();
		repeat (3) drive_cycle(idle_stim());
		drive_cycle(write_stim(ADDR_COMPARE, 32'd0));
		check_word("timer_int_o", {31'd0, timer_int}, 32'd0);

		drive_cycle(write_stim(ADDR_STATUS, 32'h0000_8001)); // ie and im7
		drive_cycle(write_stim(ADDR_COUNT, 32'd0));
		drive_cycle(write_stim(ADDR_COMPARE, 32'd8));
		wait_timer_rise();
		drive_cycle(idle_stim()); // ip7 lags by a cycle
		s = idle_stim();
		s.slot1.valid = 1'b1;
		s.slot1.pc = 32'h8000_1000;
		drive_cycle(s);
		check_word("cause_o.exc_code", {27'd0, cause[6:2]}, 32'd0);
		check_word("status_o.exl", {31'd0, status[1]}, 32'd1);

		drive_cycle(write_stim(ADDR_COMPARE, 32'd0));
		drive_cycle(idle_stim());
		s.slot1.exc = EXC_ERET;
		drive_cycle(s);
		check_word("status_o.exl", {31'd0, status[1]}, 32'd0);

		random_cycles(200, 1'b0, 1'b1, 1'b1, 0); // int_i on ip7
		random_cycles(300, 1'b1, 1'b1, 1'b1, 30);

		drive_cycle(idle_stim());
		stop_on_assertion_failure();
		$display("** PASS **");
		$finish;
	end

endmodule
